/* hdl/burst_reader.sv */
`timescale 1ns/1ns

module burst_reader import stream_pkg::*, mem_pkg::*; (
	input  logic      ti_clk,
	input  logic      rst,
	input  mem_addr_t wr_ptr,
	output mem_addr_t rd_ptr,
	output mem_req_t  req,
	input  mem_rsp_t  rsp,
	input  fifo_cnt_t out_count,
	output logic      push,
	output word_u     push_data
);

	logic      busy;
	logic      start;
	fifo_cnt_t issued;
	fifo_cnt_t returned;
	mem_addr_t issue_addr;
	mem_addr_t avail;

	// words waiting in memory, modulo the array size
	assign avail = wr_ptr - rd_ptr;

	assign start = !busy && (avail >= mem_addr_t'(BURST_LEN))
		&& (out_count <= fifo_cnt_t'(OUT_DEPTH - BURST_LEN));

	always_comb begin
		req.valid = busy && (issued != fifo_cnt_t'(BURST_LEN));
		req.write = 1'b0;
		req.addr  = issue_addr;
		req.data  = '0;
	end

	assign push      = busy && rsp.rvalid;
	assign push_data = rsp.rdata;

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			busy       <= 1'b0;
			issued     <= '0;
			returned   <= '0;
			issue_addr <= '0;
			rd_ptr     <= '0;
		end else begin
			if (start) begin
				busy       <= 1'b1;
				issued     <= '0;
				returned   <= '0;
				issue_addr <= rd_ptr;
			end
			if (busy && rsp.grant) begin
				issue_addr <= issue_addr + 1'b1;
				issued     <= issued + 1'b1;
			end
			// rd_ptr follows the returned data, not the issued address
			if (push) begin
				rd_ptr   <= rd_ptr + 1'b1;
				returned <= returned + 1'b1;
				if (returned == fifo_cnt_t'(BURST_LEN - 1)) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// room was checked at burst start, one burst in flight
	a_no_push_full: assert property (@(posedge ti_clk) disable iff (rst)
		push |-> out_count != fifo_cnt_t'(OUT_DEPTH))
		else $error("burst_reader pushed into a full output FIFO");

endmodule

/* hdl/burst_writer.sv */
`timescale 1ns/1ns

module burst_writer import stream_pkg::*, mem_pkg::*; (
	input  logic      ti_clk,
	input  logic      rst,
	input  word_u     head,
	input  fifo_cnt_t count,
	output logic      pop,
	output mem_req_t  req,
	input  mem_rsp_t  rsp,
	output mem_addr_t wr_ptr
);

	logic      busy;
	fifo_cnt_t beat;

	// address and data only move on a grant, so the request is stable
	always_comb begin
		req.valid = busy;
		req.write = 1'b1;
		req.addr  = wr_ptr;
		req.data  = head;
	end

	assign pop = busy && rsp.grant;

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			busy   <= 1'b0;
			beat   <= '0;
			wr_ptr <= '0;
		end else if (!busy) begin
			if (count >= fifo_cnt_t'(BURST_LEN)) begin
				busy <= 1'b1;
				beat <= '0;
			end
		end else if (rsp.grant) begin
			// pointer wraps with the address width, never waits on the reader
			wr_ptr <= wr_ptr + 1'b1;
			beat   <= beat + 1'b1;
			if (beat == fifo_cnt_t'(BURST_LEN - 1)) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

/* hdl/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter import stream_pkg::*, mem_pkg::*; (
	input  logic     ti_clk,
	input  logic     rst,
	input  mem_req_t wr_req,
	input  mem_req_t rd_req,
	output mem_rsp_t wr_rsp,
	output mem_rsp_t rd_rsp
);

	word_u    mem [MEM_WORDS];
	logic     last_rd;
	logic     wr_gnt;
	logic     rd_gnt;
	mem_req_t sel;
	logic     wr_rv_q;
	logic     rd_rv_q;
	word_u    rdata_q;

	//////////////////////////////////////////////////////////////////////
	// round robin, with both requesting the peer not served last wins
	//////////////////////////////////////////////////////////////////////

	assign wr_gnt = wr_req.valid && (!rd_req.valid || last_rd);
	assign rd_gnt = rd_req.valid && (!wr_req.valid || !last_rd);
	assign sel    = rd_gnt ? rd_req : wr_req;

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			last_rd <= 1'b0;
			wr_rv_q <= 1'b0;
			rd_rv_q <= 1'b0;
		end else begin
			if (wr_gnt || rd_gnt) begin
				last_rd <= rd_gnt;
			end
			wr_rv_q <= wr_gnt && !wr_req.write;
			rd_rv_q <= rd_gnt && !rd_req.write;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// shared array, writes land at the grant
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (wr_gnt || rd_gnt) begin
			if (sel.write) begin
				mem[sel.addr] <= sel.data;
			end else begin
				rdata_q <= mem[sel.addr];
			end
		end
	end

	// one data register serves both peers, only one grant per cycle
	assign wr_rsp = '{grant: wr_gnt, rvalid: wr_rv_q, rdata: rdata_q};
	assign rd_rsp = '{grant: rd_gnt, rvalid: rd_rv_q, rdata: rdata_q};

	a_one_grant: assert property (@(posedge ti_clk) disable iff (rst)
		!(wr_rsp.grant && rd_rsp.grant))
		else $error("mem_arbiter granted both peers");

endmodule

/* hdl/mem_pkg.sv */
package mem_pkg;

	import stream_pkg::*;

	// shared on-chip buffer memory
	localparam int MEM_AW    = 8;
	localparam int MEM_WORDS = 256;

	// words moved per burst, two words are four samples
	localparam int BURST_LEN = 2;

	typedef logic [MEM_AW-1:0] mem_addr_t;

	// request from one peer, held until granted
	typedef struct packed {
		logic      valid;
		logic      write;
		mem_addr_t addr;
		word_u     data;
	} mem_req_t;

	// grant in the request cycle, read data one cycle later
	typedef struct packed {
		logic  grant;
		logic  rvalid;
		word_u rdata;
	} mem_rsp_t;

endpackage

/* hdl/sample_packer.sv */
`timescale 1ns/1ns

module sample_packer import stream_pkg::*; (
	input  logic      ti_clk,
	input  logic      rst,
	input  logic      wr_en,
	input  sample_t   data_in,
	input  logic      pop,
	output word_u     head,
	output fifo_cnt_t count,
	output logic      pending
);

	word_u                       mem [IN_DEPTH];
	logic [$clog2(IN_DEPTH)-1:0] wr_idx;
	logic [$clog2(IN_DEPTH)-1:0] rd_idx;
	sample_t                     half_q;
	word_u                       pair_word;
	logic                        do_push;
	logic                        do_pop;

	// the second sample of a pair completes the word
	// a full array drops it
	assign do_push = wr_en && pending && (count != fifo_cnt_t'(IN_DEPTH));
	assign do_pop  = pop && (count != '0);

	always_comb begin
		pair_word.pair.lo = half_q;
		pair_word.pair.hi = data_in;
	end

	// show-ahead head for the burst writer
	assign head = mem[rd_idx];

	always_ff @(posedge ti_clk) begin
		if (wr_en && !pending) begin
			half_q <= data_in;
		end
		if (do_push) begin
			mem[wr_idx] <= pair_word;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			pending <= 1'b0;
			wr_idx  <= '0;
			rd_idx  <= '0;
			count   <= '0;
		end else begin
			if (wr_en) begin
				pending <= !pending;
			end
			if (do_push) begin
				wr_idx <= wr_idx + 1'b1;
			end
			if (do_pop) begin
				rd_idx <= rd_idx + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// the writer only starts a burst on a full pair of words
	a_no_pop_empty: assert property (@(posedge ti_clk) disable iff (rst)
		pop |-> count != '0)
		else $error("sample_packer popped while empty");

endmodule

/* hdl/stream_buffer.sv */
`timescale 1ns/1ns

module stream_buffer import stream_pkg::*, mem_pkg::*; (
	input  logic    ti_clk,
	input  logic    rst,
	input  logic    wr_en,
	input  sample_t data_in,
	input  logic    rd_en,
	output word_u   data_out,
	output fill_t   fill_count
);

	word_u     pk_head;
	fifo_cnt_t pk_count;
	logic      pk_pending;
	logic      pk_pop;
	mem_req_t  wr_req;
	mem_req_t  rd_req;
	mem_rsp_t  wr_rsp;
	mem_rsp_t  rd_rsp;
	mem_addr_t wr_ptr;
	mem_addr_t rd_ptr;
	logic      out_push;
	word_u     out_data;
	fifo_cnt_t out_count;
	mem_addr_t mem_diff;
	fill_t     fill_next;

	//////////////////////////////////////////////////////////////////////
	// input stage, memory peers and output stage
	//////////////////////////////////////////////////////////////////////

	sample_packer i_sample_packer (
		.ti_clk  (ti_clk),
		.rst     (rst),
		.wr_en   (wr_en),
		.data_in (data_in),
		.pop     (pk_pop),
		.head    (pk_head),
		.count   (pk_count),
		.pending (pk_pending)
	);

	burst_writer i_burst_writer (
		.ti_clk (ti_clk),
		.rst    (rst),
		.head   (pk_head),
		.count  (pk_count),
		.pop    (pk_pop),
		.req    (wr_req),
		.rsp    (wr_rsp),
		.wr_ptr (wr_ptr)
	);

	burst_reader i_burst_reader (
		.ti_clk    (ti_clk),
		.rst       (rst),
		.wr_ptr    (wr_ptr),
		.rd_ptr    (rd_ptr),
		.req       (rd_req),
		.rsp       (rd_rsp),
		.out_count (out_count),
		.push      (out_push),
		.push_data (out_data)
	);

	mem_arbiter i_mem_arbiter (
		.ti_clk (ti_clk),
		.rst    (rst),
		.wr_req (wr_req),
		.rd_req (rd_req),
		.wr_rsp (wr_rsp),
		.rd_rsp (rd_rsp)
	);

	word_fifo i_word_fifo (
		.ti_clk    (ti_clk),
		.rst       (rst),
		.push      (out_push),
		.push_data (out_data),
		.rd_en     (rd_en),
		.data_out  (data_out),
		.count     (out_count)
	);

	//////////////////////////////////////////////////////////////////////
	// fill monitor in samples, two per word plus the pending half
	//////////////////////////////////////////////////////////////////////

	assign mem_diff  = wr_ptr - rd_ptr;
	assign fill_next = fill_t'({mem_diff, 1'b0}) + fill_t'({pk_count, 1'b0})
		+ fill_t'(pk_pending) + fill_t'({out_count, 1'b0});

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			fill_count <= '0;
		end else begin
			fill_count <= fill_next;
		end
	end

endmodule

/* hdl/stream_pkg.sv */
package stream_pkg;

	// one acquisition sample from the front end
	typedef logic [15:0] sample_t;

	// host word, seen either raw or as two samples
	// lo is the earlier of the pair
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			sample_t hi;
			sample_t lo;
		} pair;
	} word_u;

	// mini-FIFO depths in words
	localparam int IN_DEPTH  = 32;
	localparam int OUT_DEPTH = 32;

	// occupancy of a mini-FIFO, 0 to 32 words
	typedef logic [5:0] fifo_cnt_t;

	// fill monitor in samples
	typedef logic [31:0] fill_t;

endpackage

/* hdl/word_fifo.sv */
`timescale 1ns/1ns

module word_fifo import stream_pkg::*; (
	input  logic      ti_clk,
	input  logic      rst,
	input  logic      push,
	input  word_u     push_data,
	input  logic      rd_en,
	output word_u     data_out,
	output fifo_cnt_t count
);

	word_u                        mem [OUT_DEPTH];
	logic [$clog2(OUT_DEPTH)-1:0] wr_idx;
	logic [$clog2(OUT_DEPTH)-1:0] rd_idx;
	logic                         do_push;
	logic                         do_pop;

	assign do_push = push && (count != fifo_cnt_t'(OUT_DEPTH));
	// empty read is ignored, data_out keeps the last word
	assign do_pop  = rd_en && (count != '0);

	always_ff @(posedge ti_clk) begin
		if (do_push) begin
			mem[wr_idx] <= push_data;
		end
	end

	always_ff @(posedge ti_clk) begin
		if (rst) begin
			wr_idx   <= '0;
			rd_idx   <= '0;
			count    <= '0;
			data_out <= '0;
		end else begin
			if (do_push) begin
				wr_idx <= wr_idx + 1'b1;
			end
			if (do_pop) begin
				data_out <= mem[rd_idx];
				rd_idx   <= rd_idx + 1'b1;
			end
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_stream_buffer \
	--Mdir obj_dir -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

	int errors = 0;
	int checks = 0;

	// host word compare, shown raw in hex
	task automatic check_word(input string name, input word_u got, input word_u expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got.raw, expected.raw);
		end
	endtask

	// fill monitor compare in samples
	task automatic check_fill(input string name, input fill_t got, input fill_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, expected);
		end
	endtask

`endif

/* sim/tb_stream_buffer.sv */
`timescale 1ns/1ns

module tb_stream_buffer import stream_pkg::*; ();

	localparam int CLK_PERIOD  = 8;
	localparam int NUM_TESTS   = 12;
	localparam int TEST_CYCLES = 2000;
	localparam int MAX_SAMPLES = 400;
	localparam int SETTLE_WAIT = 200;
	localparam int READ_CHUNK  = 16;

	logic    ti_clk;
	logic    rst;
	logic    wr_en;
	sample_t data_in;
	logic    rd_en;
	word_u   data_out;
	fill_t   fill_count;

	// reference model, samples in write order
	sample_t model_q[$];
	word_u   last_word;
	int      samples_in;
	int      words_out;
	int      test_num;
	int      test_errors;

	`include "tb_checks.svh"

	stream_buffer i_stream_buffer (
		.ti_clk     (ti_clk),
		.rst        (rst),
		.wr_en      (wr_en),
		.data_in    (data_in),
		.rd_en      (rd_en),
		.data_out   (data_out),
		.fill_count (fill_count)
	);

	initial begin
		ti_clk = 1'b0;
		forever #(CLK_PERIOD / 2) ti_clk = ~ti_clk;
	end

	// watchdog
	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("timeout, the run did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
		$display("Something failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge ti_clk);
		#1;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) step();
	endtask

	task automatic apply_reset();
		rst   = 1'b1;
		wr_en = 1'b0;
		rd_en = 1'b0;
		idle(8);
		rst = 1'b0;
		model_q.delete();
		last_word  = '0;
		samples_in = 0;
		words_out  = 0;
		step();
	endtask

	// only whole bursts of four samples reach the output
	function automatic int readable_words();
		return (samples_in / 4) * 2 - words_out;
	endfunction

	task automatic write_sample(input sample_t s);
		wr_en   = 1'b1;
		data_in = s;
		model_q.push_back(s);
		samples_in++;
		step();
		wr_en = 1'b0;
	endtask

	task automatic write_batch(input int n);
		repeat (n) begin
			write_sample(sample_t'($urandom));
			idle($urandom_range(0, 3));
		end
	endtask

	// popped word shows on data_out right after the edge
	task automatic read_word();
		word_u expected;
		rd_en = 1'b1;
		step();
		rd_en = 1'b0;
		if (readable_words() > 0) begin
			expected.pair.lo = model_q.pop_front();
			expected.pair.hi = model_q.pop_front();
			last_word = expected;
			words_out++;
		end
		check_word("data_out", data_out, last_word);
	endtask

	task automatic wait_fill(input fill_t expected);
		int waited;
		waited = 0;
		while (fill_count !== expected && waited < SETTLE_WAIT) begin
			step();
			waited++;
		end
	endtask

	task automatic settle_and_check();
		wait_fill(fill_t'(model_q.size()));
		check_fill("fill_count", fill_count, fill_t'(model_q.size()));
	endtask

	task automatic drain_all();
		while (readable_words() > 0) begin
			idle(100);
			repeat ((readable_words() < READ_CHUNK) ? readable_words() : READ_CHUNK) begin
				read_word();
			end
		end
		settle_and_check();
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
		test_errors = errors;
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_after_reset();
		check_fill("fill_count", fill_count, '0);
		check_word("data_out", data_out, '0);
		end_test("after reset");
	endtask

	task automatic test_batches();
		int batches;
		int n;
		batches = $urandom_range(1, 3);
		repeat (batches) begin
			n = 4 * $urandom_range(1, 16);
			if (model_q.size() + n < MAX_SAMPLES) begin
				write_batch(n);
			end
		end
		idle(100);
		check_fill("fill_count", fill_count, fill_t'(model_q.size()));
		end_test("random batches");
	endtask

	task automatic test_reads();
		int n;
		idle(100);
		n = $urandom_range(1, READ_CHUNK);
		if (n > readable_words()) begin
			n = readable_words();
		end
		repeat (n) read_word();
		settle_and_check();
		end_test("random reads");
	endtask

	task automatic test_partial();
		int k;
		drain_all();
		k = $urandom_range(1, 3);
		repeat (k) write_sample(sample_t'($urandom));
		settle_and_check();
		// no whole burst yet, so this read must find the output empty
		idle(100);
		read_word();
		check_fill("fill_count", fill_count, fill_t'(model_q.size()));
		repeat (4 - k) write_sample(sample_t'($urandom));
		idle(100);
		read_word();
		read_word();
		settle_and_check();
		end_test("partial burst");
	endtask

	task automatic test_empty_read();
		drain_all();
		repeat ($urandom_range(1, 4)) read_word();
		check_fill("fill_count", fill_count, fill_t'(model_q.size()));
		end_test("empty read");
	endtask

	task automatic test_mid_reset();
		write_batch(4 * $urandom_range(4, 12));
		apply_reset();
		check_fill("fill_count", fill_count, '0);
		check_word("data_out", data_out, '0);
		end_test("mid-stream reset");
	endtask

	initial begin
		void'($urandom(95));
		rst         = 1'b1;
		wr_en       = 1'b0;
		data_in     = '0;
		rd_en       = 1'b0;
		test_num    = 0;
		test_errors = 0;
		apply_reset();
		test_after_reset();
		repeat (3) begin
			test_batches();
			test_reads();
		end
		test_partial();
		test_empty_read();
		test_mid_reset();
		test_batches();
		test_reads();
		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+sim
hdl/stream_pkg.sv
hdl/mem_pkg.sv
hdl/sample_packer.sv
hdl/burst_writer.sv
hdl/burst_reader.sv
hdl/mem_arbiter.sv
hdl/word_fifo.sv
hdl/stream_buffer.sv
sim/tb_stream_buffer.sv
